/* camera_config.svh */
/*
 * Build-time settings for the camera sensor model and its capture path.
 * Raster size, porch and sync widths, pixel width and queue depth.
 * Include this header wherever one of these values is needed.
 */

`ifndef CAMERA_CONFIG_SVH
`define CAMERA_CONFIG_SVH

// Active raster
`define CAM_X_RESOLUTION 5
`define CAM_Y_RESOLUTION 4

// Horizontal timing in pixel clocks
`define CAM_H_FRONT_PORCH 10
`define CAM_H_BACK_PORCH 11
`define CAM_H_SYNC_WIDTH 44

// Vertical timing in lines
`define CAM_V_FRONT_PORCH 1
`define CAM_V_BACK_PORCH 2
`define CAM_V_SYNC_WIDTH 5

`define CAM_PIXEL_WIDTH 10
`define CAM_FIFO_DEPTH 4   // Entries in each output queue

`endif

/* video_timing_pkg.sv */
/*
 * Types for raster position and for the raw sensor bus.
 * Shared by the sensor model and the capture block; refer to the
 * types with video_timing_pkg:: scoped names.
 */

`include "camera_config.svh"

package video_timing_pkg;

    // Raster coordinate, wide enough for any practical sensor
    typedef logic [15:0] coord_t;

    // Raw sensor output, no back-pressure possible
    typedef struct packed {
        logic [`CAM_PIXEL_WIDTH-1:0] pixel;
        logic                        line_valid;
        logic                        frame_valid;
    } sensor_stream_t;

endpackage

/* capture_pkg.sv */
/*
 * Payload types that leave the capture path through the output queues.
 * pixel_beat_t carries one active pixel with its raster coordinates,
 * frame_summary_t carries the totals of one finished frame.
 */

`include "camera_config.svh"

package capture_pkg;

    // One active pixel, 43 bits
    typedef struct packed {
        video_timing_pkg::coord_t    x;
        video_timing_pkg::coord_t    y;
        logic [`CAM_PIXEL_WIDTH-1:0] data;
        logic                        last;   // Final active pixel of the frame
    } pixel_beat_t;

    // Per-frame totals, 48 bits
    typedef struct packed {
        logic [15:0] frame_number;
        logic [15:0] pixel_count;
        logic [15:0] checksum;       // Sum of pixel values, wraps at 2^16
    } frame_summary_t;

endpackage

/* image_gen.sv */
/*
 * Camera sensor emulator.
 * Runs free raster counters and drives a fixed test pattern together with
 * line_valid and frame_valid. Pixel data is aligned with line_valid.
 * The output is registered and cannot be stalled.
 */

`timescale 1ns/1ns

`include "camera_config.svh"

module image_gen (
    input  logic                            pixel_clock_in,
    input  logic                            reset_n_in,
    output video_timing_pkg::sensor_stream_t raw_stream
);

    // Horizontal counter wraps after sync + porches + active + 2 cycles
    localparam video_timing_pkg::coord_t H_LAST = `CAM_H_SYNC_WIDTH + `CAM_H_BACK_PORCH +
                                                  `CAM_X_RESOLUTION + `CAM_H_FRONT_PORCH + 1;
    localparam video_timing_pkg::coord_t V_LAST = `CAM_V_SYNC_WIDTH + `CAM_V_BACK_PORCH +
                                                  `CAM_Y_RESOLUTION + `CAM_V_FRONT_PORCH + 1;

    // Active window
    localparam video_timing_pkg::coord_t H_ACT_START = `CAM_H_SYNC_WIDTH + `CAM_H_BACK_PORCH;
    localparam video_timing_pkg::coord_t H_ACT_END   = H_ACT_START + `CAM_X_RESOLUTION;
    localparam video_timing_pkg::coord_t V_ACT_START = `CAM_V_SYNC_WIDTH + `CAM_V_BACK_PORCH;
    localparam video_timing_pkg::coord_t V_ACT_END   = V_ACT_START + `CAM_Y_RESOLUTION;
    localparam video_timing_pkg::coord_t V_SYNC_END  = `CAM_V_SYNC_WIDTH;

    video_timing_pkg::coord_t x_counter;
    video_timing_pkg::coord_t y_counter;
    video_timing_pkg::coord_t pixel_counter;   // Active pixel index within the frame
    logic                     active;

    // Test pattern: full scale at index 0 and 2 of every group of ten
    function automatic logic [`CAM_PIXEL_WIDTH-1:0] pattern_value(
        input video_timing_pkg::coord_t index
    );
        video_timing_pkg::coord_t phase;
        phase = index % 10;
        if (phase == 0 || phase == 2) begin
            return {`CAM_PIXEL_WIDTH{1'b1}};
        end
        return '0;
    endfunction

    assign active = (x_counter >= H_ACT_START) && (x_counter < H_ACT_END) &&
                    (y_counter >= V_ACT_START) && (y_counter < V_ACT_END);

    always_ff @(posedge pixel_clock_in) begin
        if (!reset_n_in) begin
            x_counter     <= '0;
            y_counter     <= '0;
            pixel_counter <= '0;
            raw_stream    <= '0;
        end else begin
            if (x_counter == H_LAST) begin
                x_counter <= '0;
                y_counter <= (y_counter == V_LAST) ? '0 : y_counter + 1'b1;
            end else begin
                x_counter <= x_counter + 1'b1;
            end

            raw_stream.line_valid  <= active;
            raw_stream.frame_valid <= (y_counter >= V_SYNC_END);   // Low during vertical sync
            raw_stream.pixel       <= active ? pattern_value(pixel_counter) : '0;

            if (y_counter < V_SYNC_END) begin
                pixel_counter <= '0;   // Pattern restarts every frame
            end else if (active) begin
                pixel_counter <= pixel_counter + 1'b1;
            end
        end
    end

endmodule

/* pixel_capture.sv */
/*
 * Capture front end for the raw sensor stream.
 * Tags every active pixel with x, y and a last flag and pushes it as a beat.
 * On each falling frame_valid it pushes a summary with count and checksum.
 * A frame already running when reset is released gives no summary.
 */

`timescale 1ns/1ns

`include "camera_config.svh"

module pixel_capture (
    input  logic                             pixel_clock_in,
    input  logic                             reset_n_in,
    input  video_timing_pkg::sensor_stream_t raw_stream,
    output logic                             beat_valid,
    output capture_pkg::pixel_beat_t         beat,
    output logic                             summary_valid,
    output capture_pkg::frame_summary_t      summary
);

    localparam video_timing_pkg::coord_t X_LAST = `CAM_X_RESOLUTION - 1;
    localparam video_timing_pkg::coord_t Y_LAST = `CAM_Y_RESOLUTION - 1;

    logic                     prev_line_valid;
    logic                     prev_frame_valid;
    logic                     frame_started;   // Saw the start of the current frame
    video_timing_pkg::coord_t x_count;
    video_timing_pkg::coord_t y_count;
    logic [15:0]              pixel_count;
    logic [15:0]              checksum;
    logic [15:0]              frame_number;
    logic                     pixel_active;
    logic                     line_end;
    logic                     frame_begin;
    logic                     frame_end;

    assign pixel_active = raw_stream.line_valid && raw_stream.frame_valid;
    assign line_end     = prev_line_valid && !raw_stream.line_valid;
    assign frame_begin  = !prev_frame_valid && raw_stream.frame_valid;
    assign frame_end    = prev_frame_valid && !raw_stream.frame_valid;

    always_ff @(posedge pixel_clock_in) begin
        if (!reset_n_in) begin
            prev_line_valid  <= 1'b0;
            prev_frame_valid <= 1'b1;   // A frame in flight at reset is not a new frame
            frame_started    <= 1'b0;
            x_count          <= '0;
            y_count          <= '0;
            pixel_count      <= '0;
            checksum         <= '0;
            frame_number     <= '0;
            beat_valid       <= 1'b0;
            summary_valid    <= 1'b0;
        end else begin
            prev_line_valid  <= raw_stream.line_valid;
            prev_frame_valid <= raw_stream.frame_valid;
            beat_valid       <= pixel_active;
            summary_valid    <= frame_end && frame_started;

            if (frame_begin) frame_started <= 1'b1;
            if (frame_end && frame_started) frame_number <= frame_number + 1'b1;

            if (pixel_active) x_count <= x_count + 1'b1;
            else if (!raw_stream.line_valid) x_count <= '0;

            // y advances on the falling edge of line_valid
            if (!raw_stream.frame_valid) y_count <= '0;
            else if (line_end) y_count <= y_count + 1'b1;

            if (!raw_stream.frame_valid) begin
                pixel_count <= '0;
                checksum    <= '0;
            end else if (pixel_active) begin
                pixel_count <= pixel_count + 1'b1;
                checksum    <= checksum + 16'(raw_stream.pixel);
            end
        end
    end

    // Payload registers
    always_ff @(posedge pixel_clock_in) begin
        if (pixel_active) begin
            beat.x    <= x_count;
            beat.y    <= y_count;
            beat.data <= raw_stream.pixel;
            beat.last <= (x_count == X_LAST) && (y_count == Y_LAST);
        end
        if (frame_end) begin
            summary.frame_number <= frame_number;
            summary.pixel_count  <= pixel_count;
            summary.checksum     <= checksum;
        end
    end

endmodule

/* stream_fifo.sv */
/*
 * Small queue for any payload type, set by the payload_t type parameter.
 * Push side takes a one-cycle valid pulse; pushes into a full queue are
 * dropped and set the sticky overflow flag until reset.
 * Pop side is a four-phase req/ack port with the head item held on pop_data.
 */

`timescale 1ns/1ns

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     pixel_clock_in,
    input  logic     reset_n_in,
    input  logic     push_valid,
    input  payload_t push_data,
    output logic     req,
    input  logic     ack,
    output payload_t pop_data,
    output logic     overflow
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef enum logic [1:0] {POP_IDLE, POP_REQ, POP_RELEASE} pop_state_t;

    payload_t          mem [depth];
    ptr_t              wr_ptr;
    ptr_t              rd_ptr;
    logic [CNT_W-1:0]  count;
    pop_state_t        pop_state;
    logic              push_accept;
    logic              pop_done;
    logic              have_item;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_accept = push_valid && (count != CNT_W'(depth));
    assign pop_done    = (pop_state == POP_REQ) && ack;
    assign have_item   = (count != '0) || push_valid;   // Head ready by next cycle
    assign req         = (pop_state == POP_REQ);
    assign pop_data    = mem[rd_ptr];

    always_ff @(posedge pixel_clock_in) begin
        if (!reset_n_in) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            pop_state <= POP_IDLE;
        end else begin
            if (push_accept) wr_ptr <= next_ptr(wr_ptr);
            if (pop_done) rd_ptr <= next_ptr(rd_ptr);
            if (push_accept && !pop_done) count <= count + 1'b1;
            else if (pop_done && !push_accept) count <= count - 1'b1;
            if (push_valid && !push_accept) overflow <= 1'b1;   // Sticky

            case (pop_state)
                POP_IDLE:    if (have_item && !ack) pop_state <= POP_REQ;
                POP_REQ:     if (ack) pop_state <= POP_RELEASE;     // Item removed here
                POP_RELEASE: if (!ack) pop_state <= have_item ? POP_REQ : POP_IDLE;
                default:     pop_state <= POP_IDLE;
            endcase
        end
    end

    always_ff @(posedge pixel_clock_in) begin
        if (push_accept) mem[wr_ptr] <= push_data;
    end

endmodule

/* camera_emulator_top.sv */
/*
 * Camera subsystem top level.
 * The sensor emulator feeds the capture block, which fills one queue
 * with pixel beats and one with frame summaries. Each queue is read
 * through its own four-phase req/ack port.
 */

`timescale 1ns/1ns

`include "camera_config.svh"

module camera_emulator_top (
    input  logic                        pixel_clock_in,
    input  logic                        reset_n_in,
    output logic                        pixel_req,
    input  logic                        pixel_ack,
    output capture_pkg::pixel_beat_t    pixel_out,
    output logic                        summary_req,
    input  logic                        summary_ack,
    output capture_pkg::frame_summary_t summary_out,
    output logic                        pixel_overflow,
    output logic                        summary_overflow
);

    video_timing_pkg::sensor_stream_t raw_stream;   // Raw sensor bus, no handshake
    logic                             beat_valid;
    capture_pkg::pixel_beat_t         beat;
    logic                             summary_valid;
    capture_pkg::frame_summary_t      summary;

    image_gen i_image_gen (
        .pixel_clock_in (pixel_clock_in),
        .reset_n_in     (reset_n_in),
        .raw_stream     (raw_stream)
    );

    pixel_capture i_pixel_capture (
        .pixel_clock_in (pixel_clock_in),
        .reset_n_in     (reset_n_in),
        .raw_stream     (raw_stream),
        .beat_valid     (beat_valid),
        .beat           (beat),
        .summary_valid  (summary_valid),
        .summary        (summary)
    );

    stream_fifo #(
        .payload_t (capture_pkg::pixel_beat_t),
        .depth     (`CAM_FIFO_DEPTH)
    ) pixel_queue (
        .pixel_clock_in (pixel_clock_in),
        .reset_n_in     (reset_n_in),
        .push_valid     (beat_valid),
        .push_data      (beat),
        .req            (pixel_req),
        .ack            (pixel_ack),
        .pop_data       (pixel_out),
        .overflow       (pixel_overflow)
    );

    stream_fifo #(
        .payload_t (capture_pkg::frame_summary_t),
        .depth     (`CAM_FIFO_DEPTH)
    ) summary_queue (
        .pixel_clock_in (pixel_clock_in),
        .reset_n_in     (reset_n_in),
        .push_valid     (summary_valid),
        .push_data      (summary),
        .req            (summary_req),
        .ack            (summary_ack),
        .pop_data       (summary_out),
        .overflow       (summary_overflow)
    );

endmodule

/* camera_emulator_properties.sv */
/*
 * Concurrent checks bound into the camera subsystem top level.
 * Covers the four-phase req/ack ports of both queues and the sensor
 * framing right after reset.
 */

`timescale 1ns/1ns

module camera_emulator_properties (
    input logic                        pixel_clock_in,
    input logic                        reset_n_in,
    input logic                        pixel_req,
    input logic                        pixel_ack,
    input capture_pkg::pixel_beat_t    pixel_out,
    input logic                        summary_req,
    input logic                        summary_ack,
    input capture_pkg::frame_summary_t summary_out,
    input logic                        frame_valid
);

    // req stays up until the consumer answers
    pixel_req_held: assert property (@(posedge pixel_clock_in) disable iff (!reset_n_in)
        pixel_req && !pixel_ack |=> pixel_req)
        else $error("pixel_req dropped before pixel_ack");
    summary_req_held: assert property (@(posedge pixel_clock_in) disable iff (!reset_n_in)
        summary_req && !summary_ack |=> summary_req)
        else $error("summary_req dropped before summary_ack");

    // Head item must not move under an open request
    pixel_data_stable: assert property (@(posedge pixel_clock_in) disable iff (!reset_n_in)
        pixel_req && $past(pixel_req) |-> pixel_out == $past(pixel_out))
        else $error("pixel_out changed while pixel_req was high");
    summary_data_stable: assert property (@(posedge pixel_clock_in) disable iff (!reset_n_in)
        summary_req && $past(summary_req) |-> summary_out == $past(summary_out))
        else $error("summary_out changed while summary_req was high");

    // A new request only after ack was seen low
    pixel_req_rise: assert property (@(posedge pixel_clock_in) disable iff (!reset_n_in)
        pixel_req && !$past(pixel_req) |-> !$past(pixel_ack))
        else $error("pixel_req rose while pixel_ack was high");
    summary_req_rise: assert property (@(posedge pixel_clock_in) disable iff (!reset_n_in)
        summary_req && !$past(summary_req) |-> !$past(summary_ack))
        else $error("summary_req rose while summary_ack was high");

    frame_low_after_reset: assert property (@(posedge pixel_clock_in)
        $rose(reset_n_in) |-> !frame_valid)
        else $error("frame_valid high right after reset");

endmodule

bind camera_emulator_top camera_emulator_properties i_camera_emulator_properties (
    .pixel_clock_in (pixel_clock_in),
    .reset_n_in     (reset_n_in),
    .pixel_req      (pixel_req),
    .pixel_ack      (pixel_ack),
    .pixel_out      (pixel_out),
    .summary_req    (summary_req),
    .summary_ack    (summary_ack),
    .summary_out    (summary_out),
    .frame_valid    (raw_stream.frame_valid)
);

/* tb_camera_emulator.sv */
/*
 * Testbench for the camera subsystem.
 * Reads expected beats, summaries and ack delays from the trace file and
 * answers the pixel and summary ports in two parallel threads.
 * Run from the project root so the trace path resolves.
 */

`timescale 1ns/1ns

module tb_camera_emulator;

    localparam int REC_WORDS   = 6;      // kind, four fields, ack delay
    localparam int MAX_RECORDS = 64;
    localparam int TIMEOUT     = 3000;   // Cycles per wait
    localparam int DRIVE_DELAY = 5;
    localparam int ACK_RELEASE = 1;      // Cycles ack stays high after req falls

    logic                        pixel_clock_in;
    logic                        reset_n_in;
    logic                        pixel_req;
    logic                        pixel_ack;
    capture_pkg::pixel_beat_t    pixel_out;
    logic                        summary_req;
    logic                        summary_ack;
    capture_pkg::frame_summary_t summary_out;
    logic                        pixel_overflow;
    logic                        summary_overflow;

    logic [15:0] trace_mem [REC_WORDS*MAX_RECORDS];
    int          checks;
    int          value_errors;
    int          timeouts;
    bit          timed_out;

    camera_emulator_top i_camera_emulator_top (
        .pixel_clock_in   (pixel_clock_in),
        .reset_n_in       (reset_n_in),
        .pixel_req        (pixel_req),
        .pixel_ack        (pixel_ack),
        .pixel_out        (pixel_out),
        .summary_req      (summary_req),
        .summary_ack      (summary_ack),
        .summary_out      (summary_out),
        .pixel_overflow   (pixel_overflow),
        .summary_overflow (summary_overflow)
    );

    initial begin
        pixel_clock_in = 1'b0;
        forever #50 pixel_clock_in = ~pixel_clock_in;
    end

    task automatic check_field(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            value_errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge pixel_clock_in);
            #DRIVE_DELAY;
        end
    endtask

    // Port 0 is the pixel queue, port 1 the summary queue
    task automatic wait_req(input bit port, input logic level);
        int cycles;
        cycles = 0;
        while ((port ? summary_req : pixel_req) !== level && cycles < TIMEOUT && !timed_out) begin
            step_cycles(1);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout at %0t ns: %s request never went %0b", $time,
                     port ? "summary" : "pixel", level);
        end
    endtask

    task automatic deliver_beat(input int base);
        wait_req(1'b0, 1'b1);
        if (!timed_out) begin
            check_field("pixel_out.x", int'(pixel_out.x), int'(trace_mem[base+1]));
            check_field("pixel_out.y", int'(pixel_out.y), int'(trace_mem[base+2]));
            check_field("pixel_out.data", int'(pixel_out.data), int'(trace_mem[base+3]));
            check_field("pixel_out.last", int'(pixel_out.last), int'(trace_mem[base+4]));
            step_cycles(int'(trace_mem[base+5]));
            pixel_ack = 1'b1;
            wait_req(1'b0, 1'b0);
            step_cycles(ACK_RELEASE);   // Queue must not raise req while ack is still up
            pixel_ack = 1'b0;
        end
    endtask

    // Leave the head of a new frame unanswered so the queue fills up
    task automatic hold_pixel_ack(input int cycles);
        wait_req(1'b0, 1'b1);
        if (!timed_out) begin
            check_field("pixel_overflow", int'(pixel_overflow), 0);
            step_cycles(cycles);
            check_field("pixel_overflow", int'(pixel_overflow), 1);
        end
    endtask

    task automatic deliver_summary(input int base);
        wait_req(1'b1, 1'b1);
        if (!timed_out) begin
            check_field("summary_out.frame_number", int'(summary_out.frame_number),
                        int'(trace_mem[base+1]));
            check_field("summary_out.pixel_count", int'(summary_out.pixel_count),
                        int'(trace_mem[base+2]));
            check_field("summary_out.checksum", int'(summary_out.checksum),
                        int'(trace_mem[base+3]));
            step_cycles(int'(trace_mem[base+5]));
            summary_ack = 1'b1;
            wait_req(1'b1, 1'b0);
            step_cycles(ACK_RELEASE);
            summary_ack = 1'b0;
        end
    endtask

    // Walk the trace and serve the records that belong to one port
    task automatic serve_port(input bit port);
        int rec;
        int kind;
        rec  = 0;
        kind = 0;
        while (kind != 'hf && rec < MAX_RECORDS && !timed_out) begin
            kind = int'(trace_mem[rec*REC_WORDS]);
            if (!port && kind == 0) deliver_beat(rec*REC_WORDS);
            else if (!port && kind == 2) hold_pixel_ack(int'(trace_mem[rec*REC_WORDS+5]));
            else if (port && kind == 1) deliver_summary(rec*REC_WORDS);
            rec++;
        end
    endtask

    initial begin
        reset_n_in   = 1'b0;
        pixel_ack    = 1'b0;
        summary_ack  = 1'b0;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        timed_out    = 1'b0;
        $readmemh("camera_emulator_trace.txt", trace_mem);

        step_cycles(10);
        reset_n_in = 1'b1;
        check_field("pixel_req", int'(pixel_req), 0);
        check_field("summary_req", int'(summary_req), 0);

        fork
            serve_port(1'b0);
            serve_port(1'b1);
        join
        check_field("summary_overflow", int'(summary_overflow), 0);

        $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* camera_emulator_trace.txt */
// kind x_or_frame y_or_count data_or_checksum last ack_delay (hex)
// kind 0 pixel beat, 1 frame summary, 2 hold pixel ack for ack_delay cycles, f end
0 0000 0000 03ff 0 0000
0 0001 0000 0000 0 0001
0 0002 0000 03ff 0 0005
0 0003 0000 0000 0 0000
0 0004 0000 0000 0 0002
0 0000 0001 0000 0 0002
0 0001 0001 0000 0 0010
0 0002 0001 0000 0 0000
0 0003 0001 0000 0 0003
0 0004 0001 0000 0 0000
0 0000 0002 03ff 0 0001
0 0001 0002 0000 0 0000
0 0002 0002 03ff 0 0020
0 0003 0002 0000 0 0000
0 0004 0002 0000 0 0000
0 0000 0003 0000 0 0000
0 0001 0003 0000 0 0004
0 0002 0003 0000 0 0000
0 0003 0003 0000 0 0000
0 0004 0003 0000 1 0008
1 0000 0014 0ffc 0 0003
2 0000 0000 0000 0 01f4
0 0000 0000 03ff 0 0000
0 0001 0000 0000 0 0000
0 0002 0000 03ff 0 0000
0 0003 0000 0000 0 0000
1 0001 0014 0ffc 0 0040
0 0000 0000 03ff 0 0000
0 0001 0000 0000 0 0000
1 0002 0014 0ffc 0 012c
f 0000 0000 0000 0 0000

/* project.f */
+incdir+.
video_timing_pkg.sv
capture_pkg.sv
image_gen.sv
pixel_capture.sv
stream_fifo.sv
camera_emulator_top.sv
camera_emulator_properties.sv
tb_camera_emulator.sv

/* Makefile */
# Verilator simulation of the camera subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_camera_emulator
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
